// File: design/v_csr.sv
`timescale 1ns/1ns
`include "vcop_consts.svh"

module v_csr (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   set_en,      // Accepted vsetvli
    input  logic [`VCOP_ELEM_W-1:0] avl,
    input  logic                   avl_is_x0,
    output logic [`VCOP_VL_W-1:0]  vl,
    output logic [`VCOP_VL_W-1:0]  new_vl
);

    logic avl_big;

    // AVL of 4 or more clamps to VLMAX
    assign avl_big = (|avl[`VCOP_ELEM_W-1:`VCOP_VL_W]) ||
                     (avl[`VCOP_VL_W-1:0] > `VCOP_VL_MAX);
    assign new_vl  = (avl_is_x0 || avl_big) ? `VCOP_VL_MAX : avl[`VCOP_VL_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vl <= `VCOP_VL_MAX;                 // Full length out of reset
        end else if (set_en) begin
            vl <= new_vl;
        end
    end

    a_vl_range: assert property (@(posedge clk) disable iff (!rst_n) vl <= `VCOP_VL_MAX)
        else $error("vl above VLMAX");

endmodule

// File: design/v_decoder.sv
`timescale 1ns/1ns
`include "vcop_consts.svh"

module v_decoder (
    input  vcop_pkg::xword_t    instr,
    output vcop_pkg::v_op_e     op,
    output vcop_pkg::opsrc_e    a_src,
    output vcop_pkg::reg_addr_t vd,
    output vcop_pkg::reg_addr_t vs1,
    output vcop_pkg::reg_addr_t vs2,
    output vcop_pkg::elem_t     imm,
    output logic                legal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [5:0] funct6;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct6 = instr[31:26];
    assign vd     = instr[11:7];             // Also rd for scalar results
    assign vs1    = instr[19:15];            // Also rs1 and imm5
    assign vs2    = instr[24:20];
    assign imm    = {{(`VCOP_ELEM_W-5){1'b0}}, instr[19:15]};  // Zero extended imm5

    always_comb begin
        op    = vcop_pkg::OP_NONE;
        a_src = vcop_pkg::SRC_VEC;
        if (opcode == `VCOP_OPV) begin
            case (funct3)
                `VCOP_F3_OPIVV, `VCOP_F3_OPIVX, `VCOP_F3_OPIVI: begin
                    case (funct6)
                        `VCOP_F6_ADD: op = vcop_pkg::OP_ADD;
                        `VCOP_F6_SUB: op = vcop_pkg::OP_SUB;
                        `VCOP_F6_AND: op = vcop_pkg::OP_AND;
                        `VCOP_F6_OR:  op = vcop_pkg::OP_OR;
                        `VCOP_F6_XOR: op = vcop_pkg::OP_XOR;
                        default:      op = vcop_pkg::OP_NONE;
                    endcase
                    // Operand class follows funct3
                    if (funct3 == `VCOP_F3_OPIVX) begin
                        a_src = vcop_pkg::SRC_SCALAR;
                    end else if (funct3 == `VCOP_F3_OPIVI) begin
                        a_src = vcop_pkg::SRC_IMM;
                    end
                end
                `VCOP_F3_OPMVV: begin
                    if (funct6 == `VCOP_F6_REDSUM) begin
                        op = vcop_pkg::OP_REDSUM;
                    end else if (funct6 == `VCOP_F6_WXUNARY0 && vs1 == '0) begin
                        op = vcop_pkg::OP_MVXS;   // vs1 field selects vmv.x.s
                    end
                end
                `VCOP_F3_OPCFG: begin
                    if (!instr[31]) begin
                        op = vcop_pkg::OP_SETVL;  // vsetvli only
                    end
                end
                default: op = vcop_pkg::OP_NONE;
            endcase
        end
    end

    // Anything outside the supported set decodes to OP_NONE
    assign legal = (op != vcop_pkg::OP_NONE);

endmodule

// File: design/v_lanes.sv
`timescale 1ns/1ns
`include "vcop_consts.svh"

module v_lanes (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  vcop_pkg::v_op_e  op,
    input  vcop_pkg::opsrc_e a_src,
    input  vcop_pkg::vreg_t  vs1_data,
    input  vcop_pkg::vreg_t  vs2_data,
    input  vcop_pkg::xword_t scalar,
    input  vcop_pkg::elem_t  imm,
    output vcop_pkg::vreg_t  result
);

    vcop_pkg::vreg_t alu_out;

    for (genvar i = 0; i < `VCOP_LANES; i++) begin : g_lane
        vcop_pkg::elem_t a;      // Operand A for this lane
        vcop_pkg::elem_t b;      // Always vs2
        vcop_pkg::elem_t res;

        assign b = vs2_data[i*`VCOP_ELEM_W +: `VCOP_ELEM_W];

        always_comb begin
            case (a_src)
                vcop_pkg::SRC_SCALAR: a = scalar;   // Broadcast rs1
                vcop_pkg::SRC_IMM:    a = imm;      // Broadcast imm5
                default:              a = vs1_data[i*`VCOP_ELEM_W +: `VCOP_ELEM_W];
            endcase
        end

        always_comb begin
            case (op)
                vcop_pkg::OP_ADD: res = b + a;
                vcop_pkg::OP_SUB: res = b - a;      // vs2 minus A
                vcop_pkg::OP_AND: res = b & a;
                vcop_pkg::OP_OR:  res = b | a;
                vcop_pkg::OP_XOR: res = b ^ a;
                default:          res = b;
            endcase
        end

        assign alu_out[i*`VCOP_ELEM_W +: `VCOP_ELEM_W] = res;
    end

    // Result captured at the accept edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (start) begin
            result <= alu_out;
        end
    end

endmodule

// File: design/v_red.sv
`timescale 1ns/1ns
`include "vcop_consts.svh"

module v_red (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  vcop_pkg::vl_t   vl,
    input  vcop_pkg::elem_t init,      // vs1[0]
    input  vcop_pkg::vreg_t src,       // vs2
    output logic            done,
    output vcop_pkg::elem_t sum
);

    logic            active;
    vcop_pkg::vl_t   cnt;              // Next element to add
    vcop_pkg::vl_t   vl_q;
    vcop_pkg::vreg_t src_q;
    vcop_pkg::elem_t acc;

    ////////////////////////////////////////////////////////////
    // One element per cycle
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            cnt    <= '0;
            vl_q   <= '0;
        end else if (start) begin
            active <= 1'b1;
            cnt    <= '0;
            vl_q   <= vl;                        // Latched for the whole run
        end else if (done) begin
            active <= 1'b0;
        end else if (active) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            src_q <= src;
            acc   <= init;
        end else if (active && !done) begin
            acc <= acc + src_q[cnt[1:0]*`VCOP_ELEM_W +: `VCOP_ELEM_W];
        end
    end

    assign done = active && (cnt == vl_q);   // Final sum in acc this cycle
    assign sum  = acc;

    // Done comes at most vl+1 cycles after its start, so within five
    a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(start, 1) || $past(start, 2) || $past(start, 3) ||
                 $past(start, 4) || $past(start, 5))
        else $error("reducer done without start");

endmodule

// File: design/v_regfile.sv
`timescale 1ns/1ns
`include "vcop_consts.svh"

module v_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  vcop_pkg::reg_addr_t rd_addr_a,
    input  vcop_pkg::reg_addr_t rd_addr_b,
    output vcop_pkg::vreg_t     rd_data_a,
    output vcop_pkg::vreg_t     rd_data_b,
    input  vcop_pkg::reg_addr_t wr_addr,
    input  vcop_pkg::elem_en_t  wr_elem_en,
    input  vcop_pkg::vreg_t     wr_data
);

    vcop_pkg::vreg_t regs [2**`VCOP_REG_BITS];

    // Async read ports for vs1 and vs2
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    ////////////////////////////////////////////////////////////
    // Write port with one enable per element
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < 2**`VCOP_REG_BITS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int e = 0; e < `VCOP_LANES; e++) begin
                if (wr_elem_en[e]) begin                   // Disabled elements keep their value
                    regs[wr_addr][e*`VCOP_ELEM_W +: `VCOP_ELEM_W] <=
                        wr_data[e*`VCOP_ELEM_W +: `VCOP_ELEM_W];
                end
            end
        end
    end

endmodule

// File: design/v_sequencer.sv
`timescale 1ns/1ns
`include "vcop_consts.svh"

module v_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  logic                legal,
    input  vcop_pkg::v_op_e     op,
    input  vcop_pkg::reg_addr_t vd,
    input  vcop_pkg::vl_t       vl,
    input  vcop_pkg::vl_t       new_vl,
    input  vcop_pkg::elem_t     vs2_elem0,
    input  vcop_pkg::vreg_t     alu_result,
    input  logic                red_done,
    input  vcop_pkg::elem_t     red_sum,
    output logic                accept,
    output logic                busy,
    output vcop_pkg::reg_addr_t wr_addr,
    output vcop_pkg::elem_en_t  wr_elem_en,
    output vcop_pkg::vreg_t     wr_data,
    output logic                xreg_wr_en,
    output vcop_pkg::reg_addr_t xreg_wr_addr,
    output vcop_pkg::xword_t    xreg_wr_data
);

    vcop_pkg::seq_state_e state;
    vcop_pkg::v_op_e      op_q;
    vcop_pkg::reg_addr_t  vd_q;
    vcop_pkg::elem_t      elem0_q;       // vs2[0] for vmv.x.s
    vcop_pkg::vl_t        nvl_q;         // vsetvli result
    vcop_pkg::elem_en_t   body_en;
    logic                 alu_op_q;

    assign accept   = instr_valid && legal && (state == vcop_pkg::ST_IDLE);
    assign busy     = (state != vcop_pkg::ST_IDLE);
    assign alu_op_q = op_q inside {vcop_pkg::OP_ADD, vcop_pkg::OP_SUB, vcop_pkg::OP_AND,
                                   vcop_pkg::OP_OR, vcop_pkg::OP_XOR};

    ////////////////////////////////////////////////////////////
    // FSM and latched instruction
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= vcop_pkg::ST_IDLE;
            op_q  <= vcop_pkg::OP_NONE;
        end else begin
            case (state)
                vcop_pkg::ST_IDLE: begin
                    if (accept) begin
                        op_q  <= op;
                        state <= (op == vcop_pkg::OP_REDSUM) ? vcop_pkg::ST_RED
                                                             : vcop_pkg::ST_WB;
                    end
                end
                vcop_pkg::ST_WB:  state <= vcop_pkg::ST_IDLE;
                vcop_pkg::ST_RED: begin
                    if (red_done) begin
                        state <= vcop_pkg::ST_IDLE;   // Sum written this cycle
                    end
                end
                default: state <= vcop_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            vd_q    <= vd;
            elem0_q <= vs2_elem0;
            nvl_q   <= new_vl;
        end
    end

    // Body elements below vl
    always_comb begin
        case (vl)
            3'd0:    body_en = 4'b0000;
            3'd1:    body_en = 4'b0001;
            3'd2:    body_en = 4'b0011;
            3'd3:    body_en = 4'b0111;
            default: body_en = 4'b1111;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Vector and scalar writeback
    ////////////////////////////////////////////////////////////
    always_comb begin
        wr_elem_en = '0;
        wr_data    = alu_result;
        if (state == vcop_pkg::ST_WB && alu_op_q) begin
            wr_elem_en = body_en;
        end else if (state == vcop_pkg::ST_RED && red_done && vl != '0) begin
            wr_elem_en = 4'b0001;                         // Element 0 only
            wr_data    = {{(`VCOP_VLEN-`VCOP_ELEM_W){1'b0}}, red_sum};
        end
    end

    assign wr_addr      = vd_q;
    assign xreg_wr_addr = vd_q;                           // rd field
    assign xreg_wr_en   = (state == vcop_pkg::ST_WB) &&
                          (op_q == vcop_pkg::OP_SETVL || op_q == vcop_pkg::OP_MVXS);
    assign xreg_wr_data = (op_q == vcop_pkg::OP_SETVL) ?
                          {{(`VCOP_ELEM_W-`VCOP_VL_W){1'b0}}, nvl_q} : elem0_q;

    // Base processor must hold off while busy
    a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !instr_valid)
        else $error("instr_valid while busy, instruction dropped");

endmodule

// File: design/vcop_consts.svh
`ifndef VCOP_CONSTS_SVH
`define VCOP_CONSTS_SVH

// Datapath geometry, SEW fixed at 32 and LMUL at 1
`define VCOP_LANES     4              // Elements per vector register
`define VCOP_ELEM_W    32             // Element and scalar word width
`define VCOP_VLEN      128            // Bits per vector register
`define VCOP_REG_BITS  5              // Vector and scalar register index width
`define VCOP_VL_W      3              // vl range 0..4
`define VCOP_VL_MAX    3'd4           // VLMAX with one register group

// Major opcode
`define VCOP_OPV       7'b1010111

// funct3 operand categories
`define VCOP_F3_OPIVV  3'b000
`define VCOP_F3_OPMVV  3'b010
`define VCOP_F3_OPIVI  3'b011
`define VCOP_F3_OPIVX  3'b100
`define VCOP_F3_OPCFG  3'b111

// funct6 codes
`define VCOP_F6_ADD      6'b000000    // OPI space
`define VCOP_F6_SUB      6'b000010
`define VCOP_F6_AND      6'b001001
`define VCOP_F6_OR       6'b001010
`define VCOP_F6_XOR      6'b001011
`define VCOP_F6_REDSUM   6'b000000    // OPM space
`define VCOP_F6_WXUNARY0 6'b010000    // vmv.x.s when vs1 field is 0

`endif

// File: design/vcop_pkg.sv
`include "vcop_consts.svh"

package vcop_pkg;

    ////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////
    typedef logic [`VCOP_ELEM_W-1:0]   elem_t;      // One vector element
    typedef logic [`VCOP_VLEN-1:0]     vreg_t;      // Whole vector register
    typedef logic [`VCOP_ELEM_W-1:0]   xword_t;     // Base processor word
    typedef logic [`VCOP_REG_BITS-1:0] reg_addr_t;  // Shared by v and x regs
    typedef logic [`VCOP_VL_W-1:0]     vl_t;
    typedef logic [`VCOP_LANES-1:0]    elem_en_t;   // One bit per element

    // Decoded operation
    typedef enum logic [3:0] {
        OP_NONE,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_REDSUM,
        OP_MVXS,
        OP_SETVL
    } v_op_e;

    // Operand A source, scalar and immediate get broadcast
    typedef enum logic [1:0] {
        SRC_VEC,
        SRC_SCALAR,
        SRC_IMM
    } opsrc_e;

    // Sequencer FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WB,      // Single writeback cycle
        ST_RED      // Waiting on the reducer
    } seq_state_e;

endpackage

// File: design/vcop_top.sv
`timescale 1ns/1ns
`include "vcop_consts.svh"

module vcop_top (
    input  logic                clk,
    input  logic                rst_n,
    input  vcop_pkg::xword_t    instr,
    input  logic                instr_valid,
    output vcop_pkg::reg_addr_t xreg_rd_addr,
    input  vcop_pkg::xword_t    xreg_rd_data,
    output logic                busy,
    output logic                xreg_wr_en,
    output vcop_pkg::reg_addr_t xreg_wr_addr,
    output vcop_pkg::xword_t    xreg_wr_data
);

    vcop_pkg::v_op_e     op;
    vcop_pkg::opsrc_e    a_src;
    vcop_pkg::reg_addr_t vd, vs1, vs2;
    vcop_pkg::elem_t     imm;
    logic                legal;
    logic                accept;
    vcop_pkg::vl_t       vl, new_vl;
    vcop_pkg::vreg_t     vs1_data, vs2_data;
    vcop_pkg::reg_addr_t wr_addr;
    vcop_pkg::elem_en_t  wr_elem_en;
    vcop_pkg::vreg_t     wr_data;
    vcop_pkg::vreg_t     alu_result;
    logic                red_done;
    vcop_pkg::elem_t     red_sum;

    assign xreg_rd_addr = vs1;             // rs1 straight from the instruction

    v_decoder u_dec (
        .instr (instr),
        .op    (op),
        .a_src (a_src),
        .vd    (vd),
        .vs1   (vs1),
        .vs2   (vs2),
        .imm   (imm),
        .legal (legal)
    );

    v_csr u_csr (
        .clk       (clk),
        .rst_n     (rst_n),
        .set_en    (accept && op == vcop_pkg::OP_SETVL),
        .avl       (xreg_rd_data),
        .avl_is_x0 (vs1 == '0),
        .vl        (vl),
        .new_vl    (new_vl)
    );

    v_regfile u_rf (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_addr_a  (vs1),
        .rd_addr_b  (vs2),
        .rd_data_a  (vs1_data),
        .rd_data_b  (vs2_data),
        .wr_addr    (wr_addr),
        .wr_elem_en (wr_elem_en),
        .wr_data    (wr_data)
    );

    v_lanes u_lanes (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (accept),
        .op       (op),
        .a_src    (a_src),
        .vs1_data (vs1_data),
        .vs2_data (vs2_data),
        .scalar   (xreg_rd_data),
        .imm      (imm),
        .result   (alu_result)
    );

    v_red u_red (
        .clk   (clk),
        .rst_n (rst_n),
        .start (accept && op == vcop_pkg::OP_REDSUM),
        .vl    (vl),
        .init  (vs1_data[`VCOP_ELEM_W-1:0]),
        .src   (vs2_data),
        .done  (red_done),
        .sum   (red_sum)
    );

    v_sequencer u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .legal        (legal),
        .op           (op),
        .vd           (vd),
        .vl           (vl),
        .new_vl       (new_vl),
        .vs2_elem0    (vs2_data[`VCOP_ELEM_W-1:0]),
        .alu_result   (alu_result),
        .red_done     (red_done),
        .red_sum      (red_sum),
        .accept       (accept),
        .busy         (busy),
        .wr_addr      (wr_addr),
        .wr_elem_en   (wr_elem_en),
        .wr_data      (wr_data),
        .xreg_wr_en   (xreg_wr_en),
        .xreg_wr_addr (xreg_wr_addr),
        .xreg_wr_data (xreg_wr_data)
    );

endmodule

// File: list.f
+incdir+design
design/vcop_pkg.sv
design/v_decoder.sv
design/v_csr.sv
design/v_regfile.sv
design/v_lanes.sv
design/v_red.sv
design/v_sequencer.sv
design/vcop_top.sv
tb/tb_vcop.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the vector coprocessor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_vcop \
    -Mdir obj_dir -o sim_vcop

out=$(./obj_dir/sim_vcop)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi

// File: tb/tb_vcop.sv
`timescale 1ns/1ns
`include "vcop_consts.svh"

module tb_vcop;

    localparam int TIMEOUT = 50;                 // Cycles allowed per wait loop

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic        instr_valid;
    logic [4:0]  xreg_rd_addr;
    logic [31:0] xreg_rd_data;
    logic        busy;
    logic        xreg_wr_en;
    logic [4:0]  xreg_wr_addr;
    logic [31:0] xreg_wr_data;

    logic [31:0]  xregs  [32];                   // Base processor register file
    logic [127:0] vmodel [32];                   // Reference copy of the vector regs
    int           model_vl;
    integer       seed;
    int           errors;
    int           checks;
    int           tests_clean;
    int           mark;                          // Error count at test start

    vcop_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .xreg_rd_addr (xreg_rd_addr),
        .xreg_rd_data (xreg_rd_data),
        .busy         (busy),
        .xreg_wr_en   (xreg_wr_en),
        .xreg_wr_addr (xreg_wr_addr),
        .xreg_wr_data (xreg_wr_data)
    );

    assign xreg_rd_data = xregs[xreg_rd_addr];   // Same-cycle scalar read

    always #2 clk = ~clk;                        // 4 ns period

    ////////////////////////////////////////////////////////////
    // Encoding and reference helpers
    ////////////////////////////////////////////////////////////
    function automatic int urand(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // funct6 | vm | vs2 | vs1/rs1/imm5 | funct3 | vd | opcode
    function automatic logic [31:0] enc_arith(input logic [5:0] f6, input logic [4:0] vs2,
                                              input logic [4:0] src1, input logic [2:0] f3,
                                              input logic [4:0] vd);
        return {f6, 1'b1, vs2, src1, f3, vd, `VCOP_OPV};
    endfunction

    function automatic logic [5:0] alu_f6(input int k);
        case (k)
            0:       return `VCOP_F6_ADD;
            1:       return `VCOP_F6_SUB;
            2:       return `VCOP_F6_AND;
            3:       return `VCOP_F6_OR;
            default: return `VCOP_F6_XOR;
        endcase
    endfunction

    // Element result of vs2 op A
    function automatic logic [31:0] alu_ref(input int k, input logic [31:0] b,
                                            input logic [31:0] a);
        case (k)
            0:       return b + a;
            1:       return b - a;
            2:       return b & a;
            3:       return b | a;
            default: return b ^ a;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Bus tasks entered and left on a falling edge
    ////////////////////////////////////////////////////////////
    task automatic send(input logic [31:0] word);
        instr       = word;
        instr_valid = 1'b1;
        @(posedge clk);                          // Accept edge
        @(negedge clk);
        checks++;
        if (xreg_rd_addr !== word[19:15]) begin  // rs1 field of the instruction
            $display("error at %0t ns: xreg_rd_addr = %0d, expected %0d",
                     $time, xreg_rd_addr, word[19:15]);
            errors++;
        end
        instr_valid = 1'b0;                      // Dropped before busy is sampled
    endtask

    task automatic wait_idle(output int cycles);
        int n;
        n = 0;
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            $display("timeout at %0t ns: busy never went low", $time);
            errors++;
        end
        cycles = n;
    endtask

    task automatic wait_xwrite(output logic [4:0] addr, output logic [31:0] data);
        int n;
        n = 0;
        while (!xreg_wr_en && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!xreg_wr_en) begin
            $display("timeout at %0t ns: no scalar write strobe seen", $time);
            errors++;
        end else if (n != 0) begin
            $display("scalar write strobe came %0d cycles late at %0t ns", n, $time);
            errors++;
        end
        addr = xreg_wr_addr;
        data = xreg_wr_data;
    endtask

    // vsetvli through x0 or through x31 holding avl
    task automatic run_setvl(input bit from_x0, input int avl);
        logic [4:0]  rd;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        int          cyc;
        int          exp_vl;
        rd = 5'(urand(32));
        if (from_x0) begin
            exp_vl = 4;
            send({1'b0, 11'd0, 5'd0, `VCOP_F3_OPCFG, rd, `VCOP_OPV});
        end else begin
            xregs[31] = 32'(avl);
            exp_vl    = (avl < 4) ? avl : 4;     // min(AVL, VLMAX)
            send({1'b0, 11'd0, 5'd31, `VCOP_F3_OPCFG, rd, `VCOP_OPV});
        end
        wait_xwrite(waddr, wdata);
        checks++;
        if (wdata !== 32'(exp_vl)) begin
            $display("error at %0t ns: xreg_wr_data = %0d, expected %0d", $time, wdata, exp_vl);
            errors++;
        end
        checks++;
        if (waddr !== rd) begin
            $display("error at %0t ns: xreg_wr_addr = %0d, expected %0d", $time, waddr, rd);
            errors++;
        end
        wait_idle(cyc);
        model_vl = exp_vl;
    endtask

    // Form 0 is vv, 1 is vx and 2 is vi
    task automatic run_alu(input int k, input int form, input logic [4:0] vd,
                           input logic [4:0] src1, input logic [4:0] vs2);
        logic [127:0] nv;
        logic [31:0]  a;
        logic [2:0]   f3;
        int           cyc;
        int           e;
        nv = vmodel[vd];                         // Tail keeps old contents
        for (e = 0; e < model_vl; e++) begin
            case (form)
                0:       a = vmodel[src1][e*32 +: 32];
                1:       a = xregs[src1];
                default: a = {27'd0, src1};      // imm5 zero extended
            endcase
            nv[e*32 +: 32] = alu_ref(k, vmodel[vs2][e*32 +: 32], a);
        end
        f3 = (form == 0) ? `VCOP_F3_OPIVV : (form == 1) ? `VCOP_F3_OPIVX : `VCOP_F3_OPIVI;
        send(enc_arith(alu_f6(k), vs2, src1, f3, vd));
        wait_idle(cyc);
        checks++;
        if (cyc != 1) begin
            $display("error at %0t ns: busy cycles = %0d, expected 1", $time, cyc);
            errors++;
        end
        vmodel[vd] = nv;
    endtask

    task automatic run_red(input logic [4:0] vd, input logic [4:0] vs1, input logic [4:0] vs2);
        logic [31:0] s;
        int          cyc;
        int          e;
        s = vmodel[vs1][31:0];
        for (e = 0; e < model_vl; e++) begin
            s = s + vmodel[vs2][e*32 +: 32];     // Wraps at 32 bits
        end
        send(enc_arith(`VCOP_F6_REDSUM, vs2, vs1, `VCOP_F3_OPMVV, vd));
        wait_idle(cyc);
        checks++;
        if (cyc != model_vl + 1) begin
            $display("error at %0t ns: busy cycles = %0d, expected %0d",
                     $time, cyc, model_vl + 1);
            errors++;
        end
        if (model_vl != 0) begin
            vmodel[vd][31:0] = s;                // Element 0 only
        end
    endtask

    // vmv.x.s and compare element 0
    task automatic read_elem0(input logic [4:0] vs2);
        logic [4:0]  rd;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        int          cyc;
        rd = 5'(urand(32));
        send(enc_arith(`VCOP_F6_WXUNARY0, vs2, 5'd0, `VCOP_F3_OPMVV, rd));
        wait_xwrite(waddr, wdata);
        checks++;
        if (wdata !== vmodel[vs2][31:0]) begin
            $display("error at %0t ns: xreg_wr_data = %h, expected %h (v%0d[0])",
                     $time, wdata, vmodel[vs2][31:0], vs2);
            errors++;
        end
        checks++;
        if (waddr !== rd) begin
            $display("error at %0t ns: xreg_wr_addr = %0d, expected %0d", $time, waddr, rd);
            errors++;
        end
        wait_idle(cyc);
    endtask

    task automatic finish_test(input int num, input string name);
        if (errors == mark) begin
            tests_clean++;
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - mark);
        end
        mark = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int         i;
        logic [4:0] vd;
        logic [4:0] va;
        seed        = 97634;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        errors      = 0;
        checks      = 0;
        tests_clean = 0;
        mark        = 0;
        model_vl    = 4;                         // vl out of reset
        for (i = 0; i < 32; i++) begin
            xregs[i]  = $random(seed);
            vmodel[i] = '0;
        end
        xregs[0] = '0;                           // x0 reads zero
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Idle outputs after reset and vsetvli with x0
        checks++;
        if (busy !== 1'b0) begin
            $display("error at %0t ns: busy = %b, expected 0", $time, busy);
            errors++;
        end
        checks++;
        if (xreg_wr_en !== 1'b0) begin
            $display("error at %0t ns: xreg_wr_en = %b, expected 0", $time, xreg_wr_en);
            errors++;
        end
        run_setvl(1'b1, 0);
        finish_test(1, "reset and vsetvli x0");

        // vsetvli with AVL from 0 to 7
        for (i = 0; i < 16; i++) begin
            run_setvl(1'b0, urand(8));
        end
        finish_test(2, "vsetvli clamp");

        // Seed lanes unevenly with short-vl vadd.vx then random ops at vl 4
        for (i = 0; i < 24; i++) begin
            run_setvl(1'b0, 1 + urand(4));
            run_alu(0, 1, 5'(urand(32)), 5'(urand(32)), 5'(urand(32)));
        end
        run_setvl(1'b1, 0);
        for (i = 0; i < 40; i++) begin
            vd = 5'(urand(32));
            run_alu(urand(5), urand(3), vd, 5'(urand(32)), 5'(urand(32)));
            read_elem0(vd);
        end
        finish_test(3, "random alu");

        // Sum reduction with vl from 1 to 4
        for (i = 0; i < 8; i++) begin
            run_setvl(1'b0, 1 + urand(4));
            vd = 5'(urand(32));
            run_red(vd, 5'(urand(32)), 5'(urand(32)));
            read_elem0(vd);
        end
        finish_test(4, "vredsum");

        // Short-vl write then a full-width sum over the destination
        for (i = 0; i < 6; i++) begin
            run_setvl(1'b0, 1 + urand(3));
            vd = 5'(urand(32));
            run_alu(urand(5), 0, vd, 5'(urand(32)), 5'(urand(32)));
            run_setvl(1'b1, 0);
            va = 5'(urand(32));
            run_red(va, 5'(urand(32)), vd);
            read_elem0(va);
        end
        finish_test(5, "tail undisturbed");

        // A vl 0 reduction leaves vd alone
        for (i = 0; i < 4; i++) begin
            run_setvl(1'b0, 0);
            vd = 5'(urand(32));
            run_red(vd, 5'(urand(32)), 5'(urand(32)));
            run_setvl(1'b1, 0);
            read_elem0(vd);
            va = 5'(urand(32));
            run_red(va, 5'(urand(32)), vd);      // Covers all four elements
            read_elem0(va);
        end
        finish_test(6, "vredsum with vl 0");

        $display("%0d checks, %0d errors, %0d of 6 tests clean", checks, errors, tests_clean);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
